/* Makefile */
# Verilator build and run for the UART testbench

VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_uart
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Result is taken from the log, so a crashed or stopped run also fails
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
+incdir+include
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
testbench/tb_uart.sv

/* include/uart_macros.svh */
// UART clock and baud defaults
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

////////////////////////////////////////
// Line timing
////////////////////////////////////////

// System clock in Hz
`define UART_FREQ 32'd50_000_000

// Line rate in baud
`define UART_RATE 32'd115_200

// Whole clock cycles in one bit period
`define UART_CLKS_PER_BIT (`UART_FREQ / `UART_RATE)

`endif

/* rtl/uart_pkg.sv */
// UART shared types
package uart_pkg;

   ////////////////////////////////////////
   // Data path widths
   ////////////////////////////////////////

   typedef logic [7:0] uart_byte_t;

   // Cycle count inside one bit
   typedef logic [15:0] bit_timer_t;

   // Start, data, stop and idle slots
   typedef logic [3:0] bit_index_t;

   ////////////////////////////////////////
   // Handshake FSMs
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,
      TX_LOAD  = 2'd1,
      TX_ACK   = 2'd2,
      TX_DRAIN = 2'd3
   } tx_load_state_e;

   typedef enum logic [1:0] {
      RX_IDLE = 2'd0,
      RX_WAIT = 2'd1,
      RX_ACK  = 2'd2
   } rx_read_state_e;

   // Sticky and per-frame error flags
   typedef struct packed {
      logic frame_err;
      logic rx_over_run;
      logic tx_over_run;
   } uart_status_t;

endpackage

/* rtl/uart_rx.sv */
// UART receiver
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_rx #(
   parameter int unsigned CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 rx_enable,
   input  logic                 rx_in,
   input  logic                 rx_req,
   output uart_pkg::uart_byte_t rx_data,
   output logic                 rx_ack,
   output logic                 rx_empty,
   output logic                 frame_err,
   output logic                 rx_over_run
);

   localparam uart_pkg::bit_timer_t BIT_LAST = uart_pkg::bit_timer_t'(CLKS_PER_BIT - 1);
   localparam uart_pkg::bit_timer_t BIT_MID  = uart_pkg::bit_timer_t'(CLKS_PER_BIT / 2);

   // Tenth sample of the frame
   localparam uart_pkg::bit_index_t IDX_STOP = 4'd9;

   uart_pkg::rx_read_state_e rx_state;
   uart_pkg::rx_read_state_e rx_state_next;
   uart_pkg::uart_byte_t     rx_shift;
   uart_pkg::uart_byte_t     rx_hold;
   uart_pkg::bit_timer_t     rx_bit_time;
   uart_pkg::bit_index_t     rx_bit_index;
   logic                     rx_sync1;
   logic                     rx_sync2;
   logic                     rx_line_prev;
   logic                     rx_armed;
   logic                     rx_busy;
   logic                     line_fall;
   logic                     mid_bit;
   logic                     sample_data;
   logic                     sample_stop;
   logic                     read_cycle;

   ////////////////////////////////////////
   // Input synchronizer
   ////////////////////////////////////////

   // Flops start high so reset does not look like a start bit
   always_ff @(posedge clk) begin
      if (reset) begin
         rx_sync1     <= 1'b1;
         rx_sync2     <= 1'b1;
         rx_line_prev <= 1'b1;
      end else begin
         rx_sync1     <= rx_in;
         rx_sync2     <= rx_sync1;
         rx_line_prev <= rx_sync2;
      end
   end

   assign line_fall   = rx_line_prev && !rx_sync2;
   assign mid_bit     = (rx_bit_time == BIT_MID);
   assign sample_data = rx_enable && rx_busy && mid_bit && (rx_bit_index != IDX_STOP);
   assign sample_stop = rx_enable && rx_busy && mid_bit && (rx_bit_index == IDX_STOP);

   ////////////////////////////////////////
   // Frame sampler and flags
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         rx_armed     <= 1'b0;
         rx_busy      <= 1'b0;
         rx_bit_time  <= '0;
         rx_bit_index <= '0;
         rx_empty     <= 1'b1;
         frame_err    <= 1'b0;
         rx_over_run  <= 1'b0;
         rx_data      <= '0;
      end else begin
         if (read_cycle && !rx_empty) begin
            rx_data  <= rx_hold;
            rx_empty <= 1'b1;
         end
         if (!rx_enable) begin
            rx_armed     <= 1'b0;
            rx_busy      <= 1'b0;
            rx_bit_time  <= '0;
            rx_bit_index <= '0;
         end else if (!rx_armed && !rx_busy) begin
            if (line_fall) begin
               rx_armed    <= 1'b1;
               rx_bit_time <= '0;
            end
         end else begin
            rx_bit_time <= (rx_bit_time == BIT_LAST) ? '0 : rx_bit_time + 16'd1;
            if (mid_bit && rx_armed) begin
               // A real start bit is still low at mid-bit
               rx_armed <= 1'b0;
               if (!rx_sync2) begin
                  rx_busy      <= 1'b1;
                  rx_bit_index <= 4'd1;
               end
            end else if (sample_stop) begin
               rx_busy      <= 1'b0;
               rx_bit_index <= '0;
               if (rx_sync2) begin
                  rx_empty    <= 1'b0;
                  frame_err   <= 1'b0;
                  // A byte read out in this same cycle is not lost
                  rx_over_run <= !rx_empty && !read_cycle;
               end else begin
                  frame_err <= 1'b1;
               end
            end else if (sample_data) begin
               rx_bit_index <= rx_bit_index + 4'd1;
            end
         end
      end
   end

   // LSB arrives first, so shift in from the top
   always_ff @(posedge clk) begin
      if (sample_data) begin
         rx_shift <= {rx_sync2, rx_shift[7:1]};
      end
      if (sample_stop && rx_sync2) begin
         rx_hold <= rx_shift;
      end
   end

   ////////////////////////////////////////
   // Read handshake
   ////////////////////////////////////////

   always_comb begin
      rx_state_next = rx_state;
      case (rx_state)
         uart_pkg::RX_IDLE: begin
            if (rx_req) begin
               rx_state_next = uart_pkg::RX_WAIT;
            end
         end
         uart_pkg::RX_WAIT: begin
            rx_state_next = rx_req ? uart_pkg::RX_ACK : uart_pkg::RX_IDLE;
         end
         uart_pkg::RX_ACK: begin
            if (!rx_req) begin
               rx_state_next = uart_pkg::RX_IDLE;
            end
         end
         default: rx_state_next = uart_pkg::RX_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rx_state <= uart_pkg::RX_IDLE;
      end else begin
         rx_state <= rx_state_next;
      end
   end

   assign read_cycle = (rx_state == uart_pkg::RX_WAIT);
   assign rx_ack     = (rx_state == uart_pkg::RX_ACK);

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
      $rose(rx_ack) |-> $past(rx_req, 1) && $past(rx_req, 2));

   a_index_range: assert property (@(posedge clk) disable iff (reset)
      rx_bit_index <= IDX_STOP);

endmodule

/* rtl/uart_top.sv */
// UART top level
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   tx_enable,
   input  logic                   rx_enable,
   input  logic                   ld_tx_req,
   input  logic                   rx_req,
   input  logic                   rx_in,
   input  uart_pkg::uart_byte_t   tx_data,
   output logic                   tx_out,
   output logic                   ld_tx_ack,
   output logic                   tx_empty,
   output logic                   rx_ack,
   output logic                   rx_empty,
   output uart_pkg::uart_byte_t   rx_data,
   output uart_pkg::uart_status_t status
);

   logic frame_err;
   logic rx_over_run;
   logic tx_over_run;

   ////////////////////////////////////////
   // Transmit and receive sections
   ////////////////////////////////////////

   uart_tx #(
      .CLKS_PER_BIT(`UART_CLKS_PER_BIT)
   ) tx0 (
      .clk         (clk),
      .reset       (reset),
      .tx_enable   (tx_enable),
      .ld_tx_req   (ld_tx_req),
      .tx_data     (tx_data),
      .ld_tx_ack   (ld_tx_ack),
      .tx_empty    (tx_empty),
      .tx_out      (tx_out),
      .tx_over_run (tx_over_run)
   );

   uart_rx #(
      .CLKS_PER_BIT(`UART_CLKS_PER_BIT)
   ) rx0 (
      .clk         (clk),
      .reset       (reset),
      .rx_enable   (rx_enable),
      .rx_in       (rx_in),
      .rx_req      (rx_req),
      .rx_data     (rx_data),
      .rx_ack      (rx_ack),
      .rx_empty    (rx_empty),
      .frame_err   (frame_err),
      .rx_over_run (rx_over_run)
   );

   // Error flags gathered for the host
   assign status = '{
      frame_err:   frame_err,
      rx_over_run: rx_over_run,
      tx_over_run: tx_over_run
   };

endmodule

/* rtl/uart_tx.sv */
// UART transmitter
`timescale 1ns/1ns
`include "uart_macros.svh"

module uart_tx #(
   parameter int unsigned CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 tx_enable,
   input  logic                 ld_tx_req,
   input  uart_pkg::uart_byte_t tx_data,
   output logic                 ld_tx_ack,
   output logic                 tx_empty,
   output logic                 tx_out,
   output logic                 tx_over_run
);

   localparam uart_pkg::bit_timer_t BIT_LAST = uart_pkg::bit_timer_t'(CLKS_PER_BIT - 1);

   // Slot 0 is the start bit, 9 the stop bit, 10 the extra idle period
   localparam uart_pkg::bit_index_t IDX_DATA_FIRST = 4'd1;
   localparam uart_pkg::bit_index_t IDX_DATA_LAST  = 4'd8;
   localparam uart_pkg::bit_index_t IDX_IDLE       = 4'd10;

   uart_pkg::tx_load_state_e tx_state;
   uart_pkg::tx_load_state_e tx_state_next;
   uart_pkg::uart_byte_t     tx_hold;
   uart_pkg::uart_byte_t     tx_shift;
   uart_pkg::bit_timer_t     tx_bit_time;
   uart_pkg::bit_index_t     tx_bit_index;
   logic                     load_cycle;
   logic                     bit_done;
   logic                     in_data_bit;

   ////////////////////////////////////////
   // Load handshake
   ////////////////////////////////////////

   always_comb begin
      tx_state_next = tx_state;
      case (tx_state)
         uart_pkg::TX_IDLE: begin
            if (ld_tx_req) begin
               tx_state_next = uart_pkg::TX_LOAD;
            end
         end
         uart_pkg::TX_LOAD: tx_state_next = uart_pkg::TX_ACK;
         uart_pkg::TX_ACK: begin
            if (!ld_tx_req) begin
               tx_state_next = uart_pkg::TX_DRAIN;
            end
         end
         // Hold off the next load until the frame has gone out
         uart_pkg::TX_DRAIN: begin
            if (tx_empty) begin
               tx_state_next = uart_pkg::TX_IDLE;
            end
         end
         default: tx_state_next = uart_pkg::TX_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         tx_state <= uart_pkg::TX_IDLE;
      end else begin
         tx_state <= tx_state_next;
      end
   end

   assign load_cycle = (tx_state == uart_pkg::TX_LOAD);
   assign ld_tx_ack  = (tx_state == uart_pkg::TX_ACK);

   ////////////////////////////////////////
   // Bit timer and serial output
   ////////////////////////////////////////

   assign bit_done    = (tx_bit_time == BIT_LAST);
   assign in_data_bit = (tx_bit_index >= IDX_DATA_FIRST) && (tx_bit_index <= IDX_DATA_LAST);

   always_ff @(posedge clk) begin
      if (reset) begin
         tx_empty     <= 1'b1;
         tx_out       <= 1'b1;
         tx_over_run  <= 1'b0;
         tx_bit_time  <= '0;
         tx_bit_index <= '0;
      end else if (load_cycle) begin
         // Busy transmitter drops the byte
         if (!tx_empty) begin
            tx_over_run <= 1'b1;
         end else begin
            tx_empty     <= 1'b0;
            tx_bit_time  <= '0;
            tx_bit_index <= '0;
         end
      end else if (!tx_empty) begin
         if (!tx_enable) begin
            // Paused frame starts over from the start bit
            tx_bit_time  <= '0;
            tx_bit_index <= '0;
            tx_out       <= 1'b1;
         end else begin
            if (tx_bit_index == '0) begin
               tx_out <= 1'b0;
            end else if (in_data_bit) begin
               tx_out <= tx_shift[0];
            end else begin
               tx_out <= 1'b1;
            end
            if (bit_done) begin
               tx_bit_time <= '0;
               if (tx_bit_index == IDX_IDLE) begin
                  tx_empty     <= 1'b1;
                  tx_bit_index <= '0;
               end else begin
                  tx_bit_index <= tx_bit_index + 4'd1;
               end
            end else begin
               tx_bit_time <= tx_bit_time + 16'd1;
            end
         end
      end
   end

   // Hold copy lets a paused frame start over with the same byte
   always_ff @(posedge clk) begin
      if (load_cycle && tx_empty) begin
         tx_hold  <= tx_data;
         tx_shift <= tx_data;
      end else if (!tx_empty && !tx_enable) begin
         tx_shift <= tx_hold;
      end else if (!tx_empty && bit_done && in_data_bit) begin
         tx_shift <= {1'b0, tx_shift[7:1]};
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Acknowledge only follows a finished load cycle
   a_ack_after_load: assert property (@(posedge clk) disable iff (reset)
      $rose(ld_tx_ack) |-> $past(load_cycle) && !load_cycle);

   // Line idles high with nothing queued
   a_idle_line: assert property (@(posedge clk) disable iff (reset)
      tx_empty |-> tx_out);

endmodule

/* testbench/tb_uart.sv */
// UART directed testbench
`timescale 1ns/1ns
`include "uart_macros.svh"

module tb_uart;

   localparam int unsigned BIT_CYCLES  = `UART_CLKS_PER_BIT;
   localparam int unsigned FRAME_LIMIT = 14 * BIT_CYCLES;
   localparam int unsigned ACK_LIMIT   = 20;

   // Selectors for the polled DUT outputs
   localparam int SIG_TX_ACK    = 0;
   localparam int SIG_TX_EMPTY  = 1;
   localparam int SIG_RX_ACK    = 2;
   localparam int SIG_RX_EMPTY  = 3;
   localparam int SIG_FRAME_ERR = 4;
   localparam int SIG_RX_OVER   = 5;

   logic                   clk = 1'b0;
   logic                   reset;
   logic                   tx_enable;
   logic                   rx_enable;
   logic                   ld_tx_req;
   logic                   rx_req;
   logic                   use_loopback;
   logic                   line_drv;
   logic                   rx_line;
   uart_pkg::uart_byte_t   tx_data;
   logic                   tx_out;
   logic                   ld_tx_ack;
   logic                   tx_empty;
   logic                   rx_ack;
   logic                   rx_empty;
   uart_pkg::uart_byte_t   rx_data;
   uart_pkg::uart_status_t status;
   logic [31:0]            lcg_state;
   int unsigned            wait_cycles;

   always #5 clk = ~clk;

   // Receive line comes from the transmitter or from the testbench
   assign rx_line = use_loopback ? tx_out : line_drv;

   uart_top dut0 (
      .clk       (clk),
      .reset     (reset),
      .tx_enable (tx_enable),
      .rx_enable (rx_enable),
      .ld_tx_req (ld_tx_req),
      .rx_req    (rx_req),
      .rx_in     (rx_line),
      .tx_data   (tx_data),
      .tx_out    (tx_out),
      .ld_tx_ack (ld_tx_ack),
      .tx_empty  (tx_empty),
      .rx_ack    (rx_ack),
      .rx_empty  (rx_empty),
      .rx_data   (rx_data),
      .status    (status)
   );

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic [7:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16];
   endfunction

   function automatic logic probe(input int sel);
      case (sel)
         SIG_TX_ACK:    return ld_tx_ack;
         SIG_TX_EMPTY:  return tx_empty;
         SIG_RX_ACK:    return rx_ack;
         SIG_RX_EMPTY:  return rx_empty;
         SIG_FRAME_ERR: return status.frame_err;
         SIG_RX_OVER:   return status.rx_over_run;
         default:       return 1'b0;
      endcase
   endfunction

   task automatic stop_on_error();
      $display("STATUS: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got == exp) else begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         stop_on_error();
      end
   endtask

   // Poll on the falling edge, where outputs are settled
   task automatic wait_level(input int sel, input logic level, input int unsigned limit,
                             input string what);
      logic done;
      done        = 1'b0;
      wait_cycles = 0;
      while (!done) begin
         @(negedge clk);
         wait_cycles++;
         if (probe(sel) == level) begin
            done = 1'b1;
         end else if (wait_cycles >= limit) begin
            $display("Timeout after %0d cycles waiting for %s", wait_cycles, what);
            stop_on_error();
         end
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      @(posedge clk);
      tx_data   <= b;
      ld_tx_req <= 1'b1;
      wait_level(SIG_TX_ACK, 1'b1, ACK_LIMIT, "ld_tx_ack high");
      // Acknowledge two cycles after the request
      assert (wait_cycles == 3) else begin
         $display("ld_tx_ack came %0d cycles after the request instead of 2", wait_cycles - 1);
         stop_on_error();
      end
      @(posedge clk);
      ld_tx_req <= 1'b0;
      wait_level(SIG_TX_ACK, 1'b0, ACK_LIMIT, "ld_tx_ack low");
   endtask

   task automatic read_byte(output logic [7:0] b);
      @(posedge clk);
      rx_req <= 1'b1;
      wait_level(SIG_RX_ACK, 1'b1, ACK_LIMIT, "rx_ack high");
      assert (wait_cycles == 3) else begin
         $display("rx_ack came %0d cycles after the request instead of 2", wait_cycles - 1);
         stop_on_error();
      end
      b = rx_data;
      @(posedge clk);
      rx_req <= 1'b0;
      wait_level(SIG_RX_ACK, 1'b0, ACK_LIMIT, "rx_ack low");
   endtask

   // Start bit, eight data bits LSB first, stop bit, then one idle period
   task automatic drive_frame(input logic [7:0] b, input logic stop_bit);
      logic [9:0] frame;
      frame = {stop_bit, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         line_drv <= frame[i];
         repeat (BIT_CYCLES - 1) @(posedge clk);
      end
      @(posedge clk);
      line_drv <= 1'b1;
      repeat (BIT_CYCLES) @(posedge clk);
   endtask

   task automatic loop_one(input logic [7:0] b);
      logic [7:0] got;
      send_byte(b);
      wait_level(SIG_RX_EMPTY, 1'b0, FRAME_LIMIT, "rx_empty low");
      wait_level(SIG_TX_EMPTY, 1'b1, FRAME_LIMIT, "tx_empty high");
      read_byte(got);
      check_val("rx_data", got, b);
      check_val("rx_empty", 8'(rx_empty), 8'h01);
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic test_reset_levels();
      @(negedge clk);
      check_val("ld_tx_ack", 8'(ld_tx_ack), 8'h00);
      check_val("rx_ack", 8'(rx_ack), 8'h00);
      check_val("status", 8'(status), 8'h00);
      check_val("tx_empty", 8'(tx_empty), 8'h01);
      check_val("rx_empty", 8'(rx_empty), 8'h01);
      check_val("tx_out", 8'(tx_out), 8'h01);
      check_val("rx_data", rx_data, 8'h00);
   endtask

   task automatic test_single_loopback();
      loop_one(8'hA5);
   endtask

   task automatic test_random_loopback();
      for (int i = 0; i < 8; i++) begin
         loop_one(next_rand());
         check_val("status", 8'(status), 8'h00);
      end
   endtask

   // Second byte lands on an unread one and replaces it
   task automatic test_rx_overrun();
      logic [7:0] b1;
      logic [7:0] b2;
      logic [7:0] got;
      b1 = next_rand();
      b2 = ~b1;
      send_byte(b1);
      wait_level(SIG_RX_EMPTY, 1'b0, FRAME_LIMIT, "rx_empty low");
      wait_level(SIG_TX_EMPTY, 1'b1, FRAME_LIMIT, "tx_empty high");
      send_byte(b2);
      wait_level(SIG_RX_OVER, 1'b1, FRAME_LIMIT, "status.rx_over_run high");
      wait_level(SIG_TX_EMPTY, 1'b1, FRAME_LIMIT, "tx_empty high");
      check_val("rx_empty", 8'(rx_empty), 8'h00);
      read_byte(got);
      check_val("rx_data", got, b2);
      check_val("rx_empty", 8'(rx_empty), 8'h01);
      check_val("status.rx_over_run", 8'(status.rx_over_run), 8'h01);
   endtask

   task automatic test_framing();
      logic [7:0] b;
      logic [7:0] got;
      @(posedge clk);
      use_loopback <= 1'b0;
      drive_frame(next_rand(), 1'b0);
      wait_level(SIG_FRAME_ERR, 1'b1, 2 * BIT_CYCLES, "status.frame_err high");
      check_val("rx_empty", 8'(rx_empty), 8'h01);
      b = next_rand();
      drive_frame(b, 1'b1);
      wait_level(SIG_RX_EMPTY, 1'b0, FRAME_LIMIT, "rx_empty low");
      check_val("status.frame_err", 8'(status.frame_err), 8'h00);
      read_byte(got);
      check_val("rx_data", got, b);
      // Good byte into an empty holder also clears the overrun flag
      check_val("status", 8'(status), 8'h00);
      @(posedge clk);
      use_loopback <= 1'b1;
   endtask

   // Load while busy is held off in DRAIN until the frame has gone out
   task automatic test_tx_busy_load();
      logic [7:0]  b1;
      logic [7:0]  b2;
      logic [7:0]  got;
      logic        done;
      int unsigned busy_cycles;
      b1 = next_rand();
      b2 = next_rand();
      send_byte(b1);
      check_val("tx_empty", 8'(tx_empty), 8'h00);
      @(posedge clk);
      tx_data   <= b2;
      ld_tx_req <= 1'b1;
      done        = 1'b0;
      busy_cycles = 0;
      while (!done) begin
         @(negedge clk);
         busy_cycles++;
         if (tx_empty) begin
            done = 1'b1;
         end else begin
            check_val("ld_tx_ack", 8'(ld_tx_ack), 8'h00);
            if (busy_cycles >= FRAME_LIMIT) begin
               $display("Timeout waiting for the busy frame to finish");
               stop_on_error();
            end
         end
      end
      wait_level(SIG_TX_ACK, 1'b1, ACK_LIMIT, "ld_tx_ack high");
      @(posedge clk);
      ld_tx_req <= 1'b0;
      wait_level(SIG_TX_ACK, 1'b0, ACK_LIMIT, "ld_tx_ack low");
      wait_level(SIG_RX_EMPTY, 1'b0, FRAME_LIMIT, "rx_empty low");
      read_byte(got);
      check_val("rx_data", got, b1);
      wait_level(SIG_RX_EMPTY, 1'b0, FRAME_LIMIT, "rx_empty low");
      wait_level(SIG_TX_EMPTY, 1'b1, FRAME_LIMIT, "tx_empty high");
      read_byte(got);
      check_val("rx_data", got, b2);
      check_val("status", 8'(status), 8'h00);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      reset        = 1'b1;
      tx_enable    = 1'b0;
      rx_enable    = 1'b0;
      ld_tx_req    = 1'b0;
      rx_req       = 1'b0;
      tx_data      = '0;
      use_loopback = 1'b1;
      line_drv     = 1'b1;
      lcg_state    = 32'd19357;
      wait_cycles  = 0;
      repeat (8) @(posedge clk);
      reset     <= 1'b0;
      tx_enable <= 1'b1;
      rx_enable <= 1'b1;
      test_reset_levels();
      test_single_loopback();
      test_random_loopback();
      test_rx_overrun();
      test_framing();
      test_tx_busy_load();
      $display("STATUS: PASS");
      $finish;
   end

endmodule
